// ==== mem_stage_pkg.sv ====
`default_nettype none

package mem_stage_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_idx_t;

    // rv32i load funct3 codes
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_op_e;

    // rv32i store funct3 codes
    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_op_e;

    // one funct3 field, read as load or store kind by mem_read / mem_write
    typedef union packed {
        load_op_e  load;
        store_op_e store;
    } mem_funct3_u;

    typedef enum logic [2:0] {
        sel_alu      = 3'd0,
        sel_u_imm    = 3'd1,
        sel_br_en    = 3'd2,
        sel_pc_plus4 = 3'd3,
        sel_load     = 3'd4
    } wb_sel_e;

    // result handed over by the execute stage
    typedef struct packed {
        word_t       pc;
        word_t       alu_out;
        word_t       rs2_data;
        word_t       u_imm;
        logic        br_en;
        reg_idx_t    rd;
        logic        mem_read;
        logic        mem_write;
        mem_funct3_u funct3;
        wb_sel_e     wb_sel;
    } exe_result_t;

    // prepared request, read and write already cleared on a trap
    typedef struct packed {
        word_t       pc;
        word_t       alu_out;
        word_t       u_imm;
        logic        br_en;
        reg_idx_t    rd;
        logic        mem_read;
        logic        mem_write;
        mem_funct3_u funct3;
        wb_sel_e     wb_sel;
        word_t       addr;
        logic [3:0]  byte_en;
        word_t       wdata;
        logic        trap;
    } mem_req_t;

    typedef struct packed {
        word_t      addr;
        word_t      wdata;
        logic [3:0] byte_en;
        logic       read;
        logic       write;
    } dmem_req_t;

    // load_data is already aligned and extended
    typedef struct packed {
        word_t    pc;
        word_t    alu_out;
        word_t    u_imm;
        logic     br_en;
        reg_idx_t rd;
        wb_sel_e  wb_sel;
        word_t    load_data;
        logic     trap;
    } wb_item_t;

    typedef struct packed {
        reg_idx_t rd;
        word_t    value;
        logic     trap;
    } wb_result_t;

endpackage

`default_nettype wire

// ==== exe_mem_reg.sv ====
`timescale 1ns/1ns
`default_nettype none

module exe_mem_reg (
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      exe_valid_i,
    input  mem_stage_pkg::exe_result_t exe_i,
    output logic                      exe_ready_o,

    output logic                      req_valid_o,
    output mem_stage_pkg::mem_req_t    req_o,
    input  logic                      req_ready_i
);

    logic                    valid_q;
    mem_stage_pkg::mem_req_t req_q;
    mem_stage_pkg::mem_req_t req_d;
    logic [1:0]              offset;
    logic [3:0]              mask;
    logic                    trap;

    assign offset = exe_i.alu_out[1:0];

    // byte mask and trap from the funct3 kind
    always_comb begin
        mask = 4'b0000;
        trap = 1'b0;
        if (exe_i.mem_read) begin
            case (exe_i.funct3.load)
                mem_stage_pkg::lw: mask = 4'b1111;
                mem_stage_pkg::lh, mem_stage_pkg::lhu: mask = 4'b0011 << offset;
                mem_stage_pkg::lb, mem_stage_pkg::lbu: mask = 4'b0001 << offset;
                default: trap = 1'b1;
            endcase
        end else if (exe_i.mem_write) begin
            case (exe_i.funct3.store)
                mem_stage_pkg::sw: mask = 4'b1111;
                mem_stage_pkg::sh: mask = 4'b0011 << offset;
                mem_stage_pkg::sb: mask = 4'b0001 << offset;
                default: trap = 1'b1;
            endcase
        end
    end

    always_comb begin
        req_d.pc        = exe_i.pc;
        req_d.alu_out   = exe_i.alu_out;
        req_d.u_imm     = exe_i.u_imm;
        req_d.br_en     = exe_i.br_en;
        req_d.rd        = exe_i.rd;
        // a load wins if both flags are set
        req_d.mem_read  = exe_i.mem_read && !trap;
        req_d.mem_write = exe_i.mem_write && !exe_i.mem_read && !trap;
        req_d.funct3    = exe_i.funct3;
        req_d.wb_sel    = exe_i.wb_sel;
        req_d.addr      = {exe_i.alu_out[31:2], 2'b00};
        req_d.byte_en   = mask;
        req_d.wdata     = exe_i.rs2_data << {offset, 3'b000};
        req_d.trap      = trap;
    end

    // slot is free when empty or drained this cycle
    assign exe_ready_o = !valid_q || req_ready_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (exe_valid_i && exe_ready_o) begin
            valid_q <= 1'b1;
        end else if (req_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (exe_valid_i && exe_ready_o) begin
            req_q <= req_d;
        end
    end

    assign req_valid_o = valid_q;
    assign req_o       = req_q;

    // every memory access downstream needs at least one lane
    a_mask_nonzero: assert property (@(posedge clk) disable iff (rst)
        req_valid_o && (req_o.mem_read || req_o.mem_write) |-> req_o.byte_en != 4'b0000);

endmodule

`default_nettype wire

// ==== mem_access.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_access (
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      req_valid_i,
    input  mem_stage_pkg::mem_req_t    req_i,
    output logic                      req_ready_o,

    output mem_stage_pkg::dmem_req_t   dmem_o,
    input  logic                      dmem_resp_i,
    input  mem_stage_pkg::word_t       dmem_rdata_i,

    output logic                      item_valid_o,
    output mem_stage_pkg::wb_item_t    item_o,
    input  logic                      item_ready_i
);

    typedef enum logic [1:0] {
        st_idle,
        st_wait,
        st_hold
    } state_e;

    state_e                     state_q;
    mem_stage_pkg::dmem_req_t   dmem_q;
    mem_stage_pkg::mem_funct3_u funct3_q;
    mem_stage_pkg::wb_item_t    item_q;
    mem_stage_pkg::wb_item_t    item_d;
    mem_stage_pkg::word_t       shifted;
    mem_stage_pkg::word_t       load_val;
    logic                       accept;
    logic                       is_mem;
    logic                       resp_done;

    // a held result that leaves this cycle frees the slot
    assign req_ready_o = (state_q == st_idle) || (state_q == st_hold && item_ready_i);
    assign accept      = req_valid_i && req_ready_o;
    assign is_mem      = req_i.mem_read || req_i.mem_write;
    assign resp_done   = (state_q == st_wait) && dmem_resp_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= st_idle;
        end else if (accept) begin
            state_q <= is_mem ? st_wait : st_hold;
        end else if (resp_done) begin
            state_q <= st_hold;
        end else if (state_q == st_hold && item_ready_i) begin
            state_q <= st_idle;
        end
    end

    always_comb begin
        item_d.pc        = req_i.pc;
        item_d.alu_out   = req_i.alu_out;
        item_d.u_imm     = req_i.u_imm;
        item_d.br_en     = req_i.br_en;
        item_d.rd        = req_i.rd;
        item_d.wb_sel    = req_i.wb_sel;
        item_d.load_data = '0;
        item_d.trap      = req_i.trap;
    end

    // align the addressed lane down to bit 0
    assign shifted = dmem_rdata_i >> {item_q.alu_out[1:0], 3'b000};

    always_comb begin
        case (funct3_q.load)
            mem_stage_pkg::lb:  load_val = {{24{shifted[7]}}, shifted[7:0]};
            mem_stage_pkg::lh:  load_val = {{16{shifted[15]}}, shifted[15:0]};
            mem_stage_pkg::lbu: load_val = {24'b0, shifted[7:0]};
            mem_stage_pkg::lhu: load_val = {16'b0, shifted[15:0]};
            default:            load_val = shifted;
        endcase
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            item_q         <= item_d;
            funct3_q       <= req_i.funct3;
            dmem_q.addr    <= req_i.addr;
            dmem_q.wdata   <= req_i.wdata;
            dmem_q.byte_en <= req_i.byte_en;
            dmem_q.read    <= req_i.mem_read;
            dmem_q.write   <= req_i.mem_write;
        end else if (resp_done) begin
            item_q.load_data <= load_val;
        end
    end

    // request only shows while waiting
    always_comb begin
        dmem_o       = dmem_q;
        dmem_o.read  = dmem_q.read && (state_q == st_wait);
        dmem_o.write = dmem_q.write && (state_q == st_wait);
    end

    assign item_valid_o = (state_q == st_hold);
    assign item_o       = item_q;

    // memory answers only the one outstanding request
    a_resp_outstanding: assert property (@(posedge clk) disable iff (rst)
        dmem_resp_i |-> state_q == st_wait);

    a_rd_wr_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(dmem_o.read && dmem_o.write));

endmodule

`default_nettype wire

// ==== mem_wb_reg.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_wb_reg (
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      item_valid_i,
    input  mem_stage_pkg::wb_item_t    item_i,
    output logic                      item_ready_o,

    output logic                      wb_valid_o,
    output mem_stage_pkg::wb_result_t  wb_o,
    input  logic                      wb_ready_i
);

    logic                      valid_q;
    logic                      accept;
    mem_stage_pkg::wb_result_t wb_q;
    mem_stage_pkg::wb_result_t wb_d;
    mem_stage_pkg::word_t      pc_plus4;

    assign pc_plus4     = item_i.pc + 32'd4;
    assign item_ready_o = !valid_q || wb_ready_i;
    assign accept       = item_valid_i && item_ready_o;

    // writeback mux, trapped items write zero
    always_comb begin
        wb_d.rd   = item_i.rd;
        wb_d.trap = item_i.trap;
        if (item_i.trap) begin
            wb_d.value = '0;
        end else begin
            case (item_i.wb_sel)
                mem_stage_pkg::sel_alu:      wb_d.value = item_i.alu_out;
                mem_stage_pkg::sel_u_imm:    wb_d.value = item_i.u_imm;
                mem_stage_pkg::sel_br_en:    wb_d.value = {31'b0, item_i.br_en};
                mem_stage_pkg::sel_pc_plus4: wb_d.value = pc_plus4;
                mem_stage_pkg::sel_load:     wb_d.value = item_i.load_data;
                default:                     wb_d.value = '0;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (wb_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wb_q <= wb_d;
        end
    end

    assign wb_valid_o = valid_q;
    assign wb_o       = wb_q;

    // stalled result must not change under the consumer
    a_wb_hold: assert property (@(posedge clk) disable iff (rst)
        wb_valid_o && !wb_ready_i |=> wb_valid_o && $stable(wb_o));

endmodule

`default_nettype wire

// ==== mem_stage_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_stage_top (
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      exe_valid_i,
    input  mem_stage_pkg::exe_result_t exe_i,
    output logic                      exe_ready_o,

    output mem_stage_pkg::dmem_req_t   dmem_o,
    input  logic                      dmem_resp_i,
    input  mem_stage_pkg::word_t       dmem_rdata_i,

    output logic                      wb_valid_o,
    output mem_stage_pkg::wb_result_t  wb_o,
    input  logic                      wb_ready_i
);

    // exe_mem_reg to mem_access
    logic                    req_valid;
    logic                    req_ready;
    mem_stage_pkg::mem_req_t req;

    // mem_access to mem_wb_reg
    logic                    item_valid;
    logic                    item_ready;
    mem_stage_pkg::wb_item_t item;

    exe_mem_reg u_exe_mem (
        .clk         (clk),
        .rst         (rst),
        .exe_valid_i (exe_valid_i),
        .exe_i       (exe_i),
        .exe_ready_o (exe_ready_o),
        .req_valid_o (req_valid),
        .req_o       (req),
        .req_ready_i (req_ready)
    );

    mem_access u_mem_access (
        .clk          (clk),
        .rst          (rst),
        .req_valid_i  (req_valid),
        .req_i        (req),
        .req_ready_o  (req_ready),
        .dmem_o       (dmem_o),
        .dmem_resp_i  (dmem_resp_i),
        .dmem_rdata_i (dmem_rdata_i),
        .item_valid_o (item_valid),
        .item_o       (item),
        .item_ready_i (item_ready)
    );

    mem_wb_reg u_mem_wb (
        .clk          (clk),
        .rst          (rst),
        .item_valid_i (item_valid),
        .item_i       (item),
        .item_ready_o (item_ready),
        .wb_valid_o   (wb_valid_o),
        .wb_o         (wb_o),
        .wb_ready_i   (wb_ready_i)
    );

endmodule

`default_nettype wire

// ==== tb_mem_stage_checks.svh ====
`ifndef TB_MEM_STAGE_CHECKS_SVH
`define TB_MEM_STAGE_CHECKS_SVH

function automatic mem_stage_pkg::exe_result_t make_item(
    input mem_stage_pkg::word_t    alu,
    input mem_stage_pkg::word_t    rs2,
    input logic                    rd_en,
    input logic                    wr_en,
    input logic [2:0]              f3,
    input mem_stage_pkg::wb_sel_e  sel,
    input mem_stage_pkg::reg_idx_t rd
);
    mem_stage_pkg::exe_result_t e;
    e           = '0;
    e.pc        = 32'h0000_1000 + {25'b0, rd, 2'b00};
    e.alu_out   = alu;
    e.rs2_data  = rs2;
    e.u_imm     = 32'habcd_e000 ^ {27'b0, rd};
    e.br_en     = rd[0];
    e.rd        = rd;
    e.mem_read  = rd_en;
    e.mem_write = wr_en;
    e.funct3    = f3;
    e.wb_sel    = sel;
    return e;
endfunction

// shift down by the byte offset, then extend per load kind
function automatic mem_stage_pkg::word_t load_expect(
    input mem_stage_pkg::word_t w,
    input logic [2:0] f3,
    input logic [1:0] off
);
    mem_stage_pkg::word_t s;
    s = w >> (8 * off);
    case (f3)
        3'b000:  return {{24{s[7]}}, s[7:0]};
        3'b001:  return {{16{s[15]}}, s[15:0]};
        3'b100:  return {24'b0, s[7:0]};
        3'b101:  return {16'b0, s[15:0]};
        default: return s;
    endcase
endfunction

task automatic answer_request();
    logic [7:0] idx;
    idx = dmem_o.addr[9:2];
    dmem_rdata_i = mem[idx];
    if (dmem_o.write) begin
        for (int b = 0; b < 4; b++) begin
            if (dmem_o.byte_en[b]) begin
                mem[idx][8*b +: 8] = dmem_o.wdata[8*b +: 8];
            end
        end
    end
    dmem_resp_i = 1'b1;
endtask

task automatic report_timeout(input string what);
    errors++;
    $display("timeout while waiting for %s", what);
endtask

task automatic check_wb(input string name, input mem_stage_pkg::wb_result_t got,
                        input mem_stage_pkg::wb_result_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("MISMATCH %s: got rd=%h value=%h trap=%h, expected rd=%h value=%h trap=%h",
                 name, got.rd, got.value, got.trap, exp.rd, exp.value, exp.trap);
    end
endtask

task automatic check_dmem(input string name, input mem_stage_pkg::dmem_req_t got,
                          input mem_stage_pkg::dmem_req_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("MISMATCH %s: got addr=%h wdata=%h be=%h rd=%h wr=%h, expected %h %h %h %h %h",
                 name, got.addr, got.wdata, got.byte_en, got.read, got.write,
                 exp.addr, exp.wdata, exp.byte_en, exp.read, exp.write);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("MISMATCH %s: got %h, expected %h", name, got, exp);
    end
endtask

// ready is sampled on the falling edge, the transfer is the next rising edge
task automatic send_item(input mem_stage_pkg::exe_result_t e);
    int t;
    @(negedge clk);
    exe_valid_i = 1'b1;
    exe_i       = e;
    t = 0;
    while (!exe_ready_o && t < 50) begin
        @(negedge clk);
        t++;
    end
    if (exe_ready_o) begin
        @(posedge clk);
    end else begin
        report_timeout("exe_ready_o");
    end
    @(negedge clk);
    exe_valid_i = 1'b0;
endtask

task automatic take_result(output mem_stage_pkg::wb_result_t r);
    int t;
    t = 0;
    r = 'x;
    while (wb_log.size() == 0 && t < 50) begin
        @(negedge clk);
        t++;
    end
    if (wb_log.size() != 0) begin
        r = wb_log.pop_front();
    end else begin
        report_timeout("a writeback result");
    end
endtask

task automatic take_request(output mem_stage_pkg::dmem_req_t r);
    int t;
    t = 0;
    r = 'x;
    while (req_log.size() == 0 && t < 50) begin
        @(negedge clk);
        t++;
    end
    if (req_log.size() != 0) begin
        r = req_log.pop_front();
    end else begin
        report_timeout("a data-port request");
    end
endtask

task automatic report_test(input string name, input int errors_before);
    $display("test %s finished with %0d errors", name, errors - errors_before);
endtask

task automatic test_reset_state();
    int e0;
    e0 = errors;
    check_bit("exe_ready_o", exe_ready_o, 1'b1);
    check_bit("wb_valid_o", wb_valid_o, 1'b0);
    check_bit("dmem_o.read", dmem_o.read, 1'b0);
    check_bit("dmem_o.write", dmem_o.write, 1'b0);
    report_test("reset_state", e0);
endtask

task automatic test_non_mem();
    mem_stage_pkg::exe_result_t items [4];
    mem_stage_pkg::wb_result_t  r;
    mem_stage_pkg::wb_result_t  exp;
    int e0;
    e0 = errors;
    items[0] = make_item(32'h1111_2222, 0, 0, 0, 0, mem_stage_pkg::sel_alu, 5'd1);
    items[1] = make_item(32'h3333_4444, 0, 0, 0, 0, mem_stage_pkg::sel_u_imm, 5'd2);
    items[2] = make_item(32'h5555_6666, 0, 0, 0, 0, mem_stage_pkg::sel_br_en, 5'd3);
    items[3] = make_item(32'h7777_8888, 0, 0, 0, 0, mem_stage_pkg::sel_pc_plus4, 5'd4);
    for (int i = 0; i < 4; i++) send_item(items[i]);
    exp.trap = 1'b0;
    for (int i = 0; i < 4; i++) begin
        take_result(r);
        exp.rd = items[i].rd;
        case (i)
            0: exp.value = items[i].alu_out;
            1: exp.value = items[i].u_imm;
            2: exp.value = {31'b0, items[i].br_en};
            default: exp.value = items[i].pc + 32'd4;
        endcase
        check_wb("wb_o", r, exp);
    end
    report_test("non_mem", e0);
endtask

task automatic store_one(input logic [2:0] f3, input logic [1:0] off,
                         input mem_stage_pkg::word_t base, input mem_stage_pkg::word_t rs2);
    mem_stage_pkg::dmem_req_t  got;
    mem_stage_pkg::dmem_req_t  exp;
    mem_stage_pkg::wb_result_t r;
    mem_stage_pkg::wb_result_t exp_wb;
    send_item(make_item(base + off, rs2, 0, 1, f3, mem_stage_pkg::sel_alu, 5'd7));
    take_request(got);
    exp.addr    = base;
    exp.wdata   = rs2 << (8 * off);
    exp.byte_en = (f3 == 3'b010) ? 4'b1111 : (f3 == 3'b001) ? (4'b0011 << off)
                                                           : (4'b0001 << off);
    exp.read    = 1'b0;
    exp.write   = 1'b1;
    check_dmem("dmem_o", got, exp);
    take_result(r);
    exp_wb = '{rd: 5'd7, value: base + off, trap: 1'b0};
    check_wb("wb_o", r, exp_wb);
endtask

task automatic test_stores();
    int e0;
    e0 = errors;
    for (int off = 0; off < 4; off++) store_one(3'b000, off[1:0], 32'h100, 32'h1234_56a5);
    store_one(3'b001, 2'd0, 32'h104, 32'h89ab_c3d2);
    store_one(3'b001, 2'd2, 32'h104, 32'h89ab_c3d2);
    store_one(3'b010, 2'd0, 32'h108, 32'hfedc_ba98);
    report_test("stores", e0);
endtask

task automatic load_one(input logic [2:0] f3, input logic [1:0] off,
                        input mem_stage_pkg::word_t base, input mem_stage_pkg::word_t w);
    mem_stage_pkg::dmem_req_t  got;
    mem_stage_pkg::wb_result_t r;
    mem_stage_pkg::wb_result_t exp_wb;
    send_item(make_item(base + off, 0, 1, 0, f3, mem_stage_pkg::sel_load, 5'd9));
    take_request(got);
    check_bit("dmem_o.read", got.read, 1'b1);
    take_result(r);
    exp_wb = '{rd: 5'd9, value: load_expect(w, f3, off), trap: 1'b0};
    check_wb("wb_o", r, exp_wb);
endtask

task automatic test_loads();
    int e0;
    e0 = errors;
    store_one(3'b010, 2'd0, 32'h200, 32'h8a7f_c3e5);
    store_one(3'b010, 2'd0, 32'h204, 32'h7f80_01ff);
    for (int off = 0; off < 4; off++) begin
        load_one(3'b000, off[1:0], 32'h200, 32'h8a7f_c3e5);
        load_one(3'b100, off[1:0], 32'h200, 32'h8a7f_c3e5);
        load_one(3'b000, off[1:0], 32'h204, 32'h7f80_01ff);
    end
    for (int off = 0; off < 4; off += 2) begin
        load_one(3'b001, off[1:0], 32'h200, 32'h8a7f_c3e5);
        load_one(3'b101, off[1:0], 32'h200, 32'h8a7f_c3e5);
        load_one(3'b001, off[1:0], 32'h204, 32'h7f80_01ff);
    end
    load_one(3'b010, 2'd0, 32'h200, 32'h8a7f_c3e5);
    report_test("loads", e0);
endtask

task automatic test_illegal();
    mem_stage_pkg::wb_result_t r;
    mem_stage_pkg::wb_result_t exp_wb;
    int e0;
    int n0;
    e0 = errors;
    n0 = req_count;
    send_item(make_item(32'h300, 0, 1, 0, 3'b011, mem_stage_pkg::sel_load, 5'd11));
    send_item(make_item(32'h304, 32'h5a5a_5a5a, 0, 1, 3'b111, mem_stage_pkg::sel_alu, 5'd12));
    take_result(r);
    exp_wb = '{rd: 5'd11, value: 32'h0, trap: 1'b1};
    check_wb("wb_o", r, exp_wb);
    take_result(r);
    exp_wb = '{rd: 5'd12, value: 32'h0, trap: 1'b1};
    check_wb("wb_o", r, exp_wb);
    checks++;
    if (req_count != n0) begin
        errors++;
        $display("illegal funct3 items still made %0d data-port requests", req_count - n0);
    end
    report_test("illegal", e0);
endtask

task automatic test_back_pressure();
    mem_stage_pkg::wb_result_t r;
    mem_stage_pkg::wb_result_t exp_wb;
    int e0;
    int accepted;
    e0 = errors;
    accepted = 0;
    @(negedge clk);
    wb_ready_i = 1'b0;
    // keep offering until the input stalls
    for (int i = 0; i < 6; i++) begin
        @(negedge clk);
        exe_valid_i = 1'b1;
        exe_i = make_item(32'h4000 + i, 0, 0, 0, 0, mem_stage_pkg::sel_alu, 5'(16 + i));
        if (!exe_ready_o) break;
        @(posedge clk);
        accepted++;
    end
    @(negedge clk);
    exe_valid_i = 1'b0;
    checks++;
    if (accepted != 3) begin
        errors++;
        $display("input accepted %0d items before stalling instead of 3", accepted);
    end
    wb_ready_i = 1'b1;
    for (int i = 0; i < accepted; i++) begin
        take_result(r);
        exp_wb = '{rd: 5'(16 + i), value: 32'h4000 + i, trap: 1'b0};
        check_wb("wb_o", r, exp_wb);
    end
    repeat (6) @(negedge clk);
    checks++;
    if (wb_log.size() != 0) begin
        errors++;
        $display("%0d extra results came out after the burst", wb_log.size());
    end
    report_test("back_pressure", e0);
endtask

`endif

// ==== tb_mem_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_mem_stage;

    logic                       clk;
    logic                       rst;
    logic                       exe_valid_i;
    mem_stage_pkg::exe_result_t exe_i;
    logic                       exe_ready_o;
    mem_stage_pkg::dmem_req_t   dmem_o;
    logic                       dmem_resp_i;
    mem_stage_pkg::word_t       dmem_rdata_i;
    logic                       wb_valid_o;
    mem_stage_pkg::wb_result_t  wb_o;
    logic                       wb_ready_i;

    integer                     seed;
    int                         errors;
    int                         checks;
    int                         req_count;
    bit                         pending;
    int                         delay_left;
    mem_stage_pkg::word_t       mem [0:255];
    mem_stage_pkg::dmem_req_t   req_log[$];
    mem_stage_pkg::wb_result_t  wb_log[$];

    mem_stage_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .exe_valid_i  (exe_valid_i),
        .exe_i        (exe_i),
        .exe_ready_o  (exe_ready_o),
        .dmem_o       (dmem_o),
        .dmem_resp_i  (dmem_resp_i),
        .dmem_rdata_i (dmem_rdata_i),
        .wb_valid_o   (wb_valid_o),
        .wb_o         (wb_o),
        .wb_ready_i   (wb_ready_i)
    );

    `include "tb_mem_stage_checks.svh"

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // results leave the DUT on a rising edge with valid and ready high
    always @(posedge clk) begin
        if (!rst && wb_valid_o && wb_ready_i) begin
            wb_log.push_back(wb_o);
        end
    end

    // memory responder, random latency of 0 to 3 cycles
    always @(negedge clk) begin
        dmem_resp_i = 1'b0;
        if (!rst && !pending && (dmem_o.read || dmem_o.write)) begin
            pending = 1'b1;
            delay_left = $random(seed) & 3;
            req_count++;
            req_log.push_back(dmem_o);
        end
        if (pending) begin
            if (delay_left == 0) begin
                answer_request();
                pending = 1'b0;
            end else begin
                delay_left--;
            end
        end
    end

    initial begin
        seed         = 32'hd2da;
        errors       = 0;
        checks       = 0;
        req_count    = 0;
        pending      = 1'b0;
        delay_left   = 0;
        rst          = 1'b1;
        exe_valid_i  = 1'b0;
        exe_i        = '0;
        dmem_resp_i  = 1'b0;
        dmem_rdata_i = '0;
        wb_ready_i   = 1'b1;
        for (int i = 0; i < 256; i++) begin
            mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h3c, i[7:0] + 8'h11};
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_reset_state();
        test_non_mem();
        test_stores();
        test_loads();
        test_illegal();
        test_back_pressure();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== mem_stage_top.f ====
+incdir+.
mem_stage_pkg.sv
exe_mem_reg.sv
mem_access.sv
mem_wb_reg.sv
mem_stage_top.sv
tb_mem_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the memory-stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f mem_stage_top.f --top-module tb_mem_stage -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "All checks passed"; then
    exit 0
fi
exit 1
